// File: build.f
+incdir+src
src/rv_exec_pkg.sv
src/instr_decode.sv
src/alu_branch_unit.sv
src/commit_latch.sv
src/execute_stage.sv
tests/execute_stage_assert.sv
tests/execute_stage_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator.
# The exit status is the simulator's, nonzero when a check fails.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
  --top-module execute_stage_tb -Mdir obj_dir

./obj_dir/Vexecute_stage_tb

// File: src/alu_branch_unit.sv
// Integer ALU with branch resolution and jump target calculation.
// Consumes the decoded control and operands and assembles the complete
// commit record in the same cycle. An invalid input yields an all-zero record.
`timescale 1ns/1ps
`default_nettype none

module alu_branch_unit (
  input  rv_exec_pkg::exec_in_t ex_in,
  input  rv_exec_pkg::ctrl_t    ctrl,
  input  rv_exec_pkg::word_t    imm,
  output rv_exec_pkg::commit_t  result
);

  import rv_exec_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_out;
  word_t pc4;
  word_t pc_rel_target;
  word_t jalr_sum;
  word_t jump_target;
  logic  br_cond;
  logic  taken;

  assign op_a = ctrl.use_pc  ? ex_in.pc : ex_in.rs1_data;
  assign op_b = ctrl.use_imm ? imm      : ex_in.rs2_data;

  always_comb begin
    case (ctrl.alu_op)
      ADD:     alu_out = op_a + op_b;
      SUB:     alu_out = op_a - op_b;
      SLL:     alu_out = op_a << op_b[4:0];
      SLT:     alu_out = word_t'($signed(op_a) < $signed(op_b));
      SLTU:    alu_out = word_t'(op_a < op_b);
      XOR:     alu_out = op_a ^ op_b;
      SRL:     alu_out = op_a >> op_b[4:0];
      SRA:     alu_out = $signed(op_a) >>> op_b[4:0];
      OR:      alu_out = op_a | op_b;
      AND:     alu_out = op_a & op_b;
      PASS_B:  alu_out = op_b;
      default: alu_out = '0;
    endcase
  end

  // Branch compare always on the register operands
  always_comb begin
    case (ctrl.funct3)
      3'b000:  br_cond = ex_in.rs1_data == ex_in.rs2_data;
      3'b001:  br_cond = ex_in.rs1_data != ex_in.rs2_data;
      3'b100:  br_cond = $signed(ex_in.rs1_data) <  $signed(ex_in.rs2_data);
      3'b101:  br_cond = $signed(ex_in.rs1_data) >= $signed(ex_in.rs2_data);
      3'b110:  br_cond = ex_in.rs1_data <  ex_in.rs2_data;
      3'b111:  br_cond = ex_in.rs1_data >= ex_in.rs2_data;
      default: br_cond = 1'b0;
    endcase
  end

  assign taken         = ctrl.branch_instr && br_cond;
  assign pc4           = ex_in.pc + word_t'(4);
  assign pc_rel_target = ex_in.pc + imm; // Branch and JAL share this adder
  assign jalr_sum      = ex_in.rs1_data + imm;
  assign jump_target   = ctrl.jalr ? (jalr_sum & ~word_t'(1)) : pc_rel_target;

  always_comb begin
    result = '0;
    if (ex_in.valid) begin
      result.valid         = 1'b1;
      result.illegal       = ctrl.illegal;
      result.wen           = ctrl.reg_write;
      result.rd            = ctrl.rd;
      result.wdata         = ctrl.jump_instr ? pc4 : alu_out; // Link value for jumps
      result.branch_instr  = ctrl.branch_instr;
      result.branch_taken  = taken;
      result.prediction    = ex_in.prediction;
      result.mispredict    = ctrl.branch_instr && (ex_in.prediction != taken);
      result.resolved_addr = taken ? pc_rel_target : pc4;
      result.jump_instr    = ctrl.jump_instr;
      result.jump_addr     = jump_target;
      result.pc            = ex_in.pc;
      result.pc4           = pc4;
    end
  end

endmodule

`default_nettype wire

// File: src/commit_latch.sv
// Execute to commit pipeline register.
// Loads the new record when pc_en is high, loads zeros when flush arrives
// together with pc_en, and holds otherwise so a stalled commit side loses
// nothing. A flush while the stage is stalled is ignored.
`timescale 1ns/1ps
`default_nettype none

module commit_latch (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 pc_en,
  input  logic                 flush,
  input  rv_exec_pkg::commit_t result,
  output rv_exec_pkg::commit_t commit
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      commit <= '0;
    end else if (flush && pc_en) begin
      commit <= '0; // Kill the item in flight
    end else if (pc_en) begin
      commit <= result;
    end
  end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
// Integer execute stage top level.
// One instruction per cycle goes through decode and the ALU and branch
// unit, and the commit record is registered one cycle later. pc_en stalls
// the stage and flush, qualified by pc_en, clears the registered record.
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  pc_en,
  input  logic                  flush,
  input  rv_exec_pkg::exec_in_t ex_in,
  output rv_exec_pkg::commit_t  commit
);

  import rv_exec_pkg::*;

  ctrl_t   ctrl;
  word_t   imm;
  commit_t result; // Unregistered commit record

  instr_decode u_decode (
    .instr (ex_in.instr),
    .ctrl  (ctrl),
    .imm   (imm)
  );

  alu_branch_unit u_exec (
    .ex_in  (ex_in),
    .ctrl   (ctrl),
    .imm    (imm),
    .result (result)
  );

  commit_latch u_latch (
    .CLK    (CLK),
    .nRST   (nRST),
    .pc_en  (pc_en),
    .flush  (flush),
    .result (result),
    .commit (commit)
  );

endmodule

`default_nettype wire

// File: src/instr_decode.sv
// RV32I decoder for the integer execute path. Turns one instruction word
// into the control bits used by the ALU and branch unit, and builds the
// sign-extended immediate for the I, U, J and B formats. Purely combinational.
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_defs.svh"

module instr_decode (
  input  rv_exec_pkg::instr_t instr,
  output rv_exec_pkg::ctrl_t  ctrl,
  output rv_exec_pkg::word_t  imm
);

  import rv_exec_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_b;
  logic       writes_rd;

  // Shared by OP and OP-IMM; only register form has SUB
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                       input logic reg_form);
    alu_op_e op;
    case (f3)
      3'b000:  op = (alt && reg_form) ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign opcode = instr[`OPCODE_RANGE];
  assign funct3 = instr[`FUNCT3_RANGE];
  assign funct7 = instr[`FUNCT7_RANGE];
  assign rd     = instr[`RD_RANGE];
  assign rs1    = instr[`RS1_RANGE];
  assign rs2    = instr[`RS2_RANGE];

  assign imm_i = {{(`XLEN-12){funct7[6]}}, funct7, rs2};
  assign imm_u = {funct7, rs2, rs1, funct3, 12'b0};
  assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ADD;
    ctrl.funct3 = funct3;
    ctrl.rd     = rd;
    imm         = '0;
    writes_rd   = 1'b0;
    case (opcode)
      `OPC_OP: begin
        ctrl.alu_op = arith_op(funct3, funct7[5], 1'b1);
        writes_rd   = 1'b1;
      end
      `OPC_OP_IMM: begin
        ctrl.alu_op  = arith_op(funct3, funct7[5], 1'b0); // funct7[5] picks SRAI
        ctrl.use_imm = 1'b1;
        imm          = imm_i;
        writes_rd    = 1'b1;
      end
      `OPC_LUI: begin
        ctrl.alu_op  = PASS_B;
        ctrl.use_imm = 1'b1;
        imm          = imm_u;
        writes_rd    = 1'b1;
      end
      `OPC_AUIPC: begin
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        imm          = imm_u;
        writes_rd    = 1'b1;
      end
      `OPC_JAL: begin
        ctrl.jump_instr = 1'b1;
        imm             = imm_j;
        writes_rd       = 1'b1; // Link value
      end
      `OPC_JALR: begin
        ctrl.jump_instr = 1'b1;
        ctrl.jalr       = 1'b1;
        imm             = imm_i;
        writes_rd       = 1'b1;
      end
      `OPC_BRANCH: begin
        imm = imm_b;
        if (funct3[2:1] == 2'b01) begin
          ctrl.illegal = 1'b1; // No compare for funct3 2 and 3
        end else begin
          ctrl.branch_instr = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
    ctrl.reg_write = writes_rd && (rd != '0);
  end

endmodule

`default_nettype wire

// File: src/rv_exec_defs.svh
// Shared widths, RV32I opcode values and instruction field positions
// for the execute stage. Include this wherever a field is sliced out of
// an instruction word or a fixed width is needed.
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// Base opcodes handled by the stage
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011

// Instruction bit ranges
`define OPCODE_RANGE 6:0
`define RD_RANGE     11:7
`define FUNCT3_RANGE 14:12
`define RS1_RANGE    19:15
`define RS2_RANGE    24:20
`define FUNCT7_RANGE 31:25

`endif

// File: src/rv_exec_pkg.sv
// Types shared by the execute stage modules and its testbench.
// Compile before any module that refers to rv_exec_pkg.
`default_nettype none
`include "rv_exec_defs.svh"

package rv_exec_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]            instr_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    PASS_B  // LUI result
  } alu_op_e;

  // One issued instruction with its operands
  typedef struct packed {
    logic   valid;
    instr_t instr;
    word_t  pc;
    word_t  rs1_data;
    word_t  rs2_data;
    logic   prediction; // Front end predicted taken
  } exec_in_t;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       use_imm;      // Operand b from immediate
    logic       use_pc;       // Operand a from pc
    reg_addr_t  rd;
    logic       reg_write;    // Only when rd is not x0
    logic       branch_instr;
    logic [2:0] funct3;
    logic       jump_instr;
    logic       jalr;
    logic       illegal;
  } ctrl_t;

  // Execute to commit record
  typedef struct packed {
    logic      valid;
    logic      illegal;
    logic      wen;
    reg_addr_t rd;
    word_t     wdata;
    logic      branch_instr;
    logic      branch_taken;
    logic      prediction;
    logic      mispredict;
    word_t     resolved_addr;
    logic      jump_instr;
    word_t     jump_addr;
    word_t     pc;
    word_t     pc4;
  } commit_t;

endpackage

`default_nettype wire

// File: tests/execute_stage_assert.sv
// Concurrent checks on the execute to commit register, bound into
// every commit_latch instance.
`timescale 1ns/1ps
`default_nettype none

module commit_latch_assert (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 pc_en,
  input rv_exec_pkg::commit_t commit
);

  a_reset_clear: assert property (@(posedge CLK) $rose(nRST) |-> commit == '0)
    else $error("commit not cleared when reset was released");

  a_mispredict_branch: assert property (@(posedge CLK) disable iff (!nRST)
    commit.mispredict |-> commit.branch_instr)
    else $error("mispredict set on a non-branch record");

  a_wen_rd: assert property (@(posedge CLK) disable iff (!nRST)
    commit.wen |-> commit.rd != '0)
    else $error("write enable set for x0");

  // Stall keeps the record
  a_hold: assert property (@(posedge CLK) disable iff (!nRST) !pc_en |=> $stable(commit))
    else $error("commit changed while pc_en was low");

endmodule

bind commit_latch commit_latch_assert u_latch_assert (
  .CLK(CLK), .nRST(nRST), .pc_en(pc_en), .commit(commit)
);

`default_nettype wire

// File: tests/execute_stage_tb.sv
// Randomized testbench for the integer execute stage.
// Drives one seeded random instruction per cycle, predicts the commit
// record with a model of the RV32I rules and compares it after each edge.
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_defs.svh"

module execute_stage_tb;

  import rv_exec_pkg::*;

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 90;

  logic       CLK;
  logic       nRST;
  logic       pc_en;
  logic       flush;
  exec_in_t   ex_in;
  commit_t    commit;
  commit_t    exp_commit;        // Model of the latch contents
  logic [2:0] exp_care;          // Jump, branch and data groups compared
  integer     seed;
  int         cycle_count = 0;

  execute_stage u_execute_stage (
    .CLK(CLK), .nRST(nRST), .pc_en(pc_en), .flush(flush), .ex_in(ex_in), .commit(commit)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      fail_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      fail_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_run($sformatf("** Error at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  // RV32I integer operations by funct3 with bit 30 as alt
  function automatic word_t arith(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    word_t r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = {31'b0, $signed(a) < $signed(b)};
      3'd3:    r = {31'b0, a < b};
      3'd4:    r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else     r = a >> b[4:0];
      end
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input word_t a, input word_t b);
    logic t;
    case (f3)
      3'd0:    t = (a == b);                  // BEQ
      3'd1:    t = (a != b);                  // BNE
      3'd4:    t = ($signed(a) < $signed(b));  // BLT
      3'd5:    t = ($signed(a) >= $signed(b)); // BGE
      3'd6:    t = (a < b);                   // BLTU
      default: t = (a >= b);                  // BGEU
    endcase
    return t;
  endfunction

  task automatic build_expected(input exec_in_t in, output commit_t exp,
                                output logic [2:0] care);
    instr_t     ins;
    logic [2:0] f3;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_b;
    logic       writes;
    ins    = in.instr;
    f3     = ins[`FUNCT3_RANGE];
    imm_i  = {{20{ins[31]}}, ins[31:20]};
    imm_u  = {ins[31:12], 12'b0};
    imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    exp    = '0;
    care   = 3'b111; // Invalid item latches all zeros
    writes = 1'b0;
    if (in.valid) begin
      exp.valid      = 1'b1;
      exp.rd         = ins[`RD_RANGE];
      exp.prediction = in.prediction;
      exp.pc         = in.pc;
      exp.pc4        = in.pc + 32'd4;
      case (ins[`OPCODE_RANGE])
        `OPC_OP:     exp.wdata = arith(f3, ins[30], in.rs1_data, in.rs2_data);
        `OPC_OP_IMM: exp.wdata = arith(f3, ins[30] && f3 == 3'd5, in.rs1_data, imm_i);
        `OPC_LUI:    exp.wdata = imm_u;
        `OPC_AUIPC:  exp.wdata = in.pc + imm_u;
        `OPC_JAL: begin
          exp.wdata      = exp.pc4;
          exp.jump_instr = 1'b1;
          exp.jump_addr  = in.pc + imm_j;
        end
        `OPC_JALR: begin
          exp.wdata      = exp.pc4;
          exp.jump_instr = 1'b1;
          exp.jump_addr  = (in.rs1_data + imm_i) & ~32'd1;
        end
        `OPC_BRANCH: begin
          if (f3[2:1] == 2'b01) begin
            exp.illegal = 1'b1;
          end else begin
            exp.branch_instr  = 1'b1;
            exp.branch_taken  = branch_cond(f3, in.rs1_data, in.rs2_data);
            exp.resolved_addr = exp.branch_taken ? in.pc + imm_b : exp.pc4;
            exp.mispredict    = in.prediction != exp.branch_taken;
          end
        end
        default: exp.illegal = 1'b1;
      endcase
      writes  = !exp.illegal && !exp.branch_instr;
      exp.wen = writes && (exp.rd != 5'd0);
      care    = {exp.jump_instr, exp.branch_instr, writes};
    end
  endtask

  task automatic drive_random();
    word_t      r;
    word_t      pcw;
    instr_t     ins;
    logic [2:0] f3;
    logic [6:0] opc;
    logic       alt_ok;
    r   = $random(seed);
    ins = $random(seed);
    pcw = $random(seed);
    f3  = ins[`FUNCT3_RANGE];
    if (r[3:0] == 4'd0) begin
      case (r[9:8])
        2'd0:    opc = 7'b0000011; // Load
        2'd1:    opc = 7'b0100011; // Store
        2'd2:    opc = 7'b0001111;
        default: opc = 7'b1110011;
      endcase
    end else begin
      case (r[7:4] % 4'd7)
        4'd0:    opc = `OPC_OP;
        4'd1:    opc = `OPC_OP_IMM;
        4'd2:    opc = `OPC_LUI;
        4'd3:    opc = `OPC_AUIPC;
        4'd4:    opc = `OPC_JAL;
        4'd5:    opc = `OPC_JALR;
        default: opc = `OPC_BRANCH;
      endcase
    end
    // Keep funct7 a real encoding where it selects the operation
    alt_ok = (f3 == 3'd5) || (opc == `OPC_OP && f3 == 3'd0);
    if (opc == `OPC_OP || (opc == `OPC_OP_IMM && (f3 == 3'd1 || f3 == 3'd5))) begin
      ins[`FUNCT7_RANGE] = {1'b0, ins[30] & alt_ok, 5'b0};
    end
    ins[`OPCODE_RANGE] = opc;
    ex_in.valid        = (r[28:26] != 3'd0);
    ex_in.instr        = ins;
    ex_in.pc           = {pcw[31:2], 2'b00};
    ex_in.rs1_data     = $random(seed);
    if (r[31:30] == 2'd0) ex_in.rs2_data = ex_in.rs1_data; // Hit the equal compares
    else                  ex_in.rs2_data = $random(seed);
    ex_in.prediction   = r[29];
    pc_en              = (r[17:10] < 8'd205);
    flush              = (r[25:18] < 8'd26);
  endtask

  task automatic check_commit();
    check_flag("valid", exp_commit.valid, commit.valid);
    check_flag("illegal", exp_commit.illegal, commit.illegal);
    check_flag("wen", exp_commit.wen, commit.wen);
    check_reg("rd", exp_commit.rd, commit.rd);
    check_flag("branch_instr", exp_commit.branch_instr, commit.branch_instr);
    check_flag("jump_instr", exp_commit.jump_instr, commit.jump_instr);
    check_flag("prediction", exp_commit.prediction, commit.prediction);
    check_flag("mispredict", exp_commit.mispredict, commit.mispredict);
    check_word("pc", exp_commit.pc, commit.pc);
    check_word("pc4", exp_commit.pc4, commit.pc4);
    if (exp_care[0]) check_word("wdata", exp_commit.wdata, commit.wdata);
    if (exp_care[1]) begin
      check_flag("branch_taken", exp_commit.branch_taken, commit.branch_taken);
      check_word("resolved_addr", exp_commit.resolved_addr, commit.resolved_addr);
    end
    if (exp_care[2]) check_word("jump_addr", exp_commit.jump_addr, commit.jump_addr);
  endtask

  initial begin
    seed       = 62;
    CLK        = 1'b0;
    nRST       = 1'b0;
    pc_en      = 1'b0;
    flush      = 1'b0;
    ex_in      = '0;
    exp_commit = '0;
    exp_care   = 3'b111;
    repeat (RESET_CYCLES) begin
      @(posedge CLK);
      #1;
      check_commit();
    end
    nRST = 1'b1;
    drive_random();
    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(posedge CLK);
      if (pc_en && flush) begin
        exp_commit = '0;
        exp_care   = 3'b111;
      end else if (pc_en) begin
        build_expected(ex_in, exp_commit, exp_care);
      end
      #1;
      check_commit();
      drive_random();
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
